// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary -f build.f --top-module dmem_subsys_tb -o Vdmem_subsys_tb

run: compile
	./obj_dir/Vdmem_subsys_tb > sim.log || true
	cat sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
+incdir+include
src/dmem_pkg.sv
src/dmem_cache_bridge.sv
src/dcache_direct.sv
src/io_regs.sv
src/dmem_subsys_top.sv
tests/wb_mem_model.sv
tests/dmem_subsys_tb.sv

// File: include/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Cache line index bits, 16 lines by default
`define DC_INDEX_BITS 4

// Word offset bits inside one line, 4 words per line
`define DC_OFFSET_BITS 2

// I/O register index bits, 8 registers
`define IO_REG_BITS 3

// Timeout budget per operation for the testbench, in clock cycles
`define DC_TB_CYCLES_PER_OP 40

`endif

// File: src/dcache_direct.sv
`include "dcache_macros.svh"

module dcache_direct
  import dmem_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // Read side from the bridge
  input  logic        cache_rd_valid,
  input  dmem_addr_u  cache_rd_addr,
  output logic        cache_rd_ready,
  output logic        cache_rd_hit,
  output logic        cache_rd_data_valid,
  output logic [31:0] cache_rd_data,

  // Write side from the bridge
  input  logic        cache_wr_valid,
  input  dmem_wr_t    cache_wr,
  output logic        cache_wr_ready,

  // Wishbone classic master
  output wb_m2s_t     wb_o,
  input  wb_s2m_t     wb_i
);

  localparam int LINES = 1 << `DC_INDEX_BITS;
  localparam int WORDS = 1 << `DC_OFFSET_BITS;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_FILL  = 2'd1;
  localparam logic [1:0] ST_WRITE = 2'd2;

  logic [DC_TAG_BITS-1:0]     tag_mem [LINES];
  logic [31:0]                data_mem [LINES][WORDS];
  logic [LINES-1:0]           valid_q;
  logic [1:0]                 state;
  logic [`DC_OFFSET_BITS-1:0] fill_cnt;
  logic                       fill_last;
  logic                       wr_hit;
  logic [31:0]                rd_data_q;
  cache_addr_t                ra;
  cache_addr_t                wa;

  assign ra = cache_rd_addr.cache;
  assign wa = cache_wr.addr.cache;

  // Tag compare, same cycle as the request
  assign cache_rd_hit = valid_q[ra.index] && (tag_mem[ra.index] == ra.tag);
  assign wr_hit       = valid_q[wa.index] && (tag_mem[wa.index] == wa.tag);

  assign cache_rd_ready = (state == ST_IDLE);
  // Store done on the write ack
  assign cache_wr_ready = (state == ST_WRITE) && wb_i.ack;
  assign fill_last      = (state == ST_FILL) && wb_i.ack && (fill_cnt == '1);
  assign cache_rd_data  = rd_data_q;

  // Bus fields follow the state and stay fixed until ack
  // Fill address comes from the bridge, which holds it during the miss
  always_comb begin
    wb_o = '0;
    case (state)
      ST_FILL: begin
        wb_o.cyc = 1'b1;
        wb_o.stb = 1'b1;
        wb_o.we  = 1'b0;
        wb_o.adr = {ra.io, ra.tag, ra.index, fill_cnt, 2'b00};
        wb_o.sel = 4'hF;
      end
      ST_WRITE: begin
        wb_o.cyc = 1'b1;
        wb_o.stb = 1'b1;
        wb_o.we  = 1'b1;
        wb_o.adr = {wa.io, wa.tag, wa.index, wa.word, 2'b00};
        wb_o.dat = cache_wr.data;
        wb_o.sel = cache_wr.strb;
      end
      default: begin
        wb_o = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state               <= ST_IDLE;
      fill_cnt            <= '0;
      valid_q             <= '0;
      cache_rd_data_valid <= 1'b0;
    end else begin
      // Data valid is a single-cycle pulse
      cache_rd_data_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          // Stores take priority over a miss in the same cycle
          if (cache_wr_valid) begin
            state <= ST_WRITE;
          end else if (cache_rd_valid && !cache_rd_hit) begin
            state    <= ST_FILL;
            fill_cnt <= '0;
          end
          if (cache_rd_valid && cache_rd_hit) begin
            cache_rd_data_valid <= 1'b1;
          end
        end
        ST_FILL: begin
          if (wb_i.ack) begin
            fill_cnt <= fill_cnt + 1'b1;
          end
          // Line complete, word goes out next cycle
          if (fill_last) begin
            state               <= ST_IDLE;
            valid_q[ra.index]   <= 1'b1;
            cache_rd_data_valid <= 1'b1;
          end
        end
        ST_WRITE: begin
          if (wb_i.ack) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && cache_rd_valid && cache_rd_hit) begin
      rd_data_q <= data_mem[ra.index][ra.word];
    end
    if ((state == ST_FILL) && wb_i.ack) begin
      data_mem[ra.index][fill_cnt] <= wb_i.dat;
      // Catch the requested word as it passes
      if (fill_cnt == ra.word) begin
        rd_data_q <= wb_i.dat;
      end
      if (fill_last) begin
        tag_mem[ra.index] <= ra.tag;
      end
    end
    // Store hit merges into the line, a miss leaves the cache alone
    if ((state == ST_IDLE) && cache_wr_valid && wr_hit) begin
      for (int b = 0; b < 4; b++) begin
        if (cache_wr.strb[b]) begin
          data_mem[wa.index][wa.word][8*b +: 8] <= cache_wr.data[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: src/dmem_cache_bridge.sv
module dmem_cache_bridge
  import dmem_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // CPU load and store port
  input  logic        dmem_ren,
  input  dmem_addr_u  dmem_raddr,
  input  logic        dmem_we,
  input  dmem_wr_t    dmem_wr,
  output logic [31:0] dmem_rdata,
  output logic        dmem_stall,

  // Cache read side
  output logic        cache_rd_valid,
  output dmem_addr_u  cache_rd_addr,
  input  logic        cache_rd_ready,
  input  logic        cache_rd_hit,
  input  logic        cache_rd_data_valid,
  input  logic [31:0] cache_rd_data,

  // Cache write side
  output logic        cache_wr_valid,
  output dmem_wr_t    cache_wr,
  input  logic        cache_wr_ready,

  // I/O register block
  output logic        io_ren,
  output dmem_addr_u  io_raddr,
  output logic        io_wen,
  output dmem_wr_t    io_wr,
  input  logic [31:0] io_rdata
);

  logic       rd_is_io;
  logic       wr_is_io;
  logic       stall_seq;
  logic       rd_fire;
  logic       wr_start;
  logic       miss_inflight;
  logic       miss_returning;
  logic       store_inflight;
  logic       last_io;
  dmem_addr_u rd_addr_q;
  dmem_wr_t   wr_q;

  // Route on address bit 31
  assign rd_is_io = dmem_raddr.io.io;
  assign wr_is_io = dmem_wr.addr.io.io;

  // Registered part of the stall, no path from the CPU request
  assign stall_seq = miss_inflight | miss_returning | store_inflight;

  // Loads go to the cache in the request cycle so hits cost no stall
  assign cache_rd_valid = dmem_ren & ~rd_is_io & ~stall_seq;
  // Address frozen while the fill is running
  assign cache_rd_addr  = miss_inflight ? rd_addr_q : dmem_raddr;
  assign rd_fire        = cache_rd_valid & cache_rd_ready;

  // First store cycle comes straight from the CPU, later cycles from wr_q
  assign wr_start       = dmem_we & ~wr_is_io & ~stall_seq;
  assign cache_wr_valid = wr_start | store_inflight;
  assign cache_wr       = store_inflight ? wr_q : dmem_wr;

  // I/O side never stalls on its own
  assign io_ren   = dmem_ren & rd_is_io & ~stall_seq;
  assign io_raddr = dmem_raddr;
  assign io_wen   = dmem_we & wr_is_io & ~stall_seq;
  assign io_wr    = dmem_wr;

  // A load the cache cannot take yet is held by the CPU
  assign dmem_stall = stall_seq | (cache_rd_valid & ~cache_rd_ready);

  // Cache word while valid, else the result of the last load
  // rd_data in the cache holds its word, so it stays usable after valid drops
  always_comb begin
    if (cache_rd_data_valid || !last_io) begin
      dmem_rdata = cache_rd_data;
    end else begin
      dmem_rdata = io_rdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      miss_inflight  <= 1'b0;
      miss_returning <= 1'b0;
      store_inflight <= 1'b0;
      last_io        <= 1'b0;
    end else begin
      // One extra stall cycle after fill data
      miss_returning <= miss_inflight & cache_rd_data_valid;

      if (rd_fire && !cache_rd_hit) begin
        miss_inflight <= 1'b1;
      end else if (cache_rd_data_valid) begin
        miss_inflight <= 1'b0;
      end

      // Stall until the write-through is acked
      if (wr_start && !cache_wr_ready) begin
        store_inflight <= 1'b1;
      end else if (cache_wr_ready) begin
        store_inflight <= 1'b0;
      end

      // Source of the most recent load
      if (io_ren) begin
        last_io <= 1'b1;
      end else if (rd_fire) begin
        last_io <= 1'b0;
      end
    end
  end

  // Request copies, only meaningful while the matching flag is set
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rd_addr_q <= dmem_raddr;
    end
    if (wr_start) begin
      wr_q <= dmem_wr;
    end
  end

endmodule

// File: src/dmem_pkg.sv
`include "dcache_macros.svh"

package dmem_pkg;

  // Tag takes whatever is left below the I/O flag
  localparam int DC_TAG_BITS = 31 - `DC_INDEX_BITS - `DC_OFFSET_BITS - 2;

  // Cache view of a data address
  typedef struct packed {
    logic                       io;
    logic [DC_TAG_BITS-1:0]     tag;
    logic [`DC_INDEX_BITS-1:0]  index;
    logic [`DC_OFFSET_BITS-1:0] word;
    logic [1:0]                 byte_off;
  } cache_addr_t;

  // I/O view of the same address
  typedef struct packed {
    logic                    io;
    logic [28-`IO_REG_BITS:0] unused;
    logic [`IO_REG_BITS-1:0] reg_idx;
    logic [1:0]              byte_off;
  } io_addr_t;

  // Bit 31 is the io flag in both views
  typedef union packed {
    cache_addr_t cache;
    io_addr_t    io;
  } dmem_addr_u;

  // One store request
  typedef struct packed {
    dmem_addr_u  addr;
    logic [31:0] data;
    logic [3:0]  strb;
  } dmem_wr_t;

  // Wishbone classic master outputs
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_m2s_t;

  // Wishbone classic slave outputs, no err or rty
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_s2m_t;

endpackage

// File: src/dmem_subsys_top.sv
module dmem_subsys_top
  import dmem_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // CPU data port
  input  logic        dmem_ren,
  input  dmem_addr_u  dmem_raddr,
  input  logic        dmem_we,
  input  dmem_wr_t    dmem_wr,
  output logic [31:0] dmem_rdata,
  output logic        dmem_stall,

  // External memory
  output wb_m2s_t     wb_o,
  input  wb_s2m_t     wb_i
);

  // Bridge to cache
  logic        cache_rd_valid;
  dmem_addr_u  cache_rd_addr;
  logic        cache_rd_ready;
  logic        cache_rd_hit;
  logic        cache_rd_data_valid;
  logic [31:0] cache_rd_data;
  logic        cache_wr_valid;
  dmem_wr_t    cache_wr;
  logic        cache_wr_ready;

  // Bridge to I/O
  logic        io_ren;
  dmem_addr_u  io_raddr;
  logic        io_wen;
  dmem_wr_t    io_wr;
  logic [31:0] io_rdata;

  dmem_cache_bridge i_bridge (
    .clk                (clk),
    .rst_n              (rst_n),
    .dmem_ren           (dmem_ren),
    .dmem_raddr         (dmem_raddr),
    .dmem_we            (dmem_we),
    .dmem_wr            (dmem_wr),
    .dmem_rdata         (dmem_rdata),
    .dmem_stall         (dmem_stall),
    .cache_rd_valid     (cache_rd_valid),
    .cache_rd_addr      (cache_rd_addr),
    .cache_rd_ready     (cache_rd_ready),
    .cache_rd_hit       (cache_rd_hit),
    .cache_rd_data_valid(cache_rd_data_valid),
    .cache_rd_data      (cache_rd_data),
    .cache_wr_valid     (cache_wr_valid),
    .cache_wr           (cache_wr),
    .cache_wr_ready     (cache_wr_ready),
    .io_ren             (io_ren),
    .io_raddr           (io_raddr),
    .io_wen             (io_wen),
    .io_wr              (io_wr),
    .io_rdata           (io_rdata)
  );

  dcache_direct i_cache (
    .clk                (clk),
    .rst_n              (rst_n),
    .cache_rd_valid     (cache_rd_valid),
    .cache_rd_addr      (cache_rd_addr),
    .cache_rd_ready     (cache_rd_ready),
    .cache_rd_hit       (cache_rd_hit),
    .cache_rd_data_valid(cache_rd_data_valid),
    .cache_rd_data      (cache_rd_data),
    .cache_wr_valid     (cache_wr_valid),
    .cache_wr           (cache_wr),
    .cache_wr_ready     (cache_wr_ready),
    .wb_o               (wb_o),
    .wb_i               (wb_i)
  );

  io_regs i_io (
    .clk     (clk),
    .rst_n   (rst_n),
    .io_ren  (io_ren),
    .io_raddr(io_raddr),
    .io_wen  (io_wen),
    .io_wr   (io_wr),
    .io_rdata(io_rdata)
  );

endmodule

// File: src/io_regs.sv
`include "dcache_macros.svh"

module io_regs
  import dmem_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        io_ren,
  input  dmem_addr_u  io_raddr,
  input  logic        io_wen,
  input  dmem_wr_t    io_wr,
  output logic [31:0] io_rdata
);

  localparam int NREGS = 1 << `IO_REG_BITS;

  logic [31:0] regs [NREGS];
  io_addr_t    ra;
  io_addr_t    wa;

  // Only the register index and byte offset matter here
  assign ra = io_raddr.io;
  assign wa = io_wr.addr.io;

  // Registers read zero out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (io_wen) begin
      for (int b = 0; b < 4; b++) begin
        if (io_wr.strb[b]) begin
          regs[wa.reg_idx][8*b +: 8] <= io_wr.data[8*b +: 8];
        end
      end
    end
  end

  // One-cycle read, held until the next load
  always_ff @(posedge clk) begin
    if (io_ren) begin
      io_rdata <= regs[ra.reg_idx];
    end
  end

endmodule

// File: tests/dmem_subsys_tb.sv
`include "dcache_macros.svh"

module dmem_subsys_tb
  import dmem_pkg::*;
();

  localparam int NUM_OPS = 400;
  localparam int WORDS   = 1 << `DC_OFFSET_BITS;
  // Eight reset reads come on top of the random operations
  localparam int TIMEOUT = `DC_TB_CYCLES_PER_OP * (NUM_OPS + 8) + 100;

  logic        clk;
  logic        rst_n;
  logic        dmem_ren;
  dmem_addr_u  dmem_raddr;
  logic        dmem_we;
  dmem_wr_t    dmem_wr;
  logic [31:0] dmem_rdata;
  logic        dmem_stall;
  wb_m2s_t     wb_o;
  wb_s2m_t     wb_i;
  logic [1:0]  wait_cycles;

  // Reference state
  logic [31:0] ref_mem [256];
  logic [31:0] io_ref [8];
  logic        sh_valid [16];
  logic [1:0]  sh_tag [16];
  logic [15:0] lfsr_q;

  int          errors;
  int          checks;
  int          cycles;
  int          issued;
  int          taken;
  int          rd_acks;
  int          wr_acks;
  logic [31:0] last_wr_adr;
  logic [31:0] last_wr_dat;
  logic [3:0]  last_wr_sel;

  dmem_subsys_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_we   (dmem_we),
    .dmem_wr   (dmem_wr),
    .dmem_rdata(dmem_rdata),
    .dmem_stall(dmem_stall),
    .wb_o      (wb_o),
    .wb_i      (wb_i)
  );

  wb_mem_model i_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .wait_cycles(wait_cycles),
    .m2s        (wb_o),
    .s2m        (wb_i)
  );

  always #4 clk = ~clk;

  // Same pattern as the external memory starts with
  function automatic logic [31:0] mem_init_word(input logic [31:0] a);
    return (a * 32'h9E3779B1) ^ {a[15:0], ~a[15:0]};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        r[8*b +: 8] = data[8*b +: 8];
      end
    end
    return r;
  endfunction

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit
  task automatic draw(input int n, output logic [31:0] v);
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    if (!cond) begin
      errors++;
      $display("Error at cycle %0d: %s", cycles, msg);
    end
  endtask

  // Bus monitor, one count per acked transfer
  always @(posedge clk) begin
    if (wb_o.cyc && wb_o.stb && wb_i.ack) begin
      if (wb_o.we) begin
        wr_acks++;
        last_wr_adr = wb_o.adr;
        last_wr_dat = wb_o.dat;
        last_wr_sel = wb_o.sel;
      end else begin
        rd_acks++;
      end
    end
  end

  // Requests the DUT takes, a request counts when stall is low at the edge
  always @(posedge clk) begin
    if (rst_n && (dmem_ren || dmem_we) && !dmem_stall) begin
      taken++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, a request never completed", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic cache_load(input logic [31:0] addr);
    logic        hit;
    logic [31:0] exp;
    int          rd0;
    int          wr0;
    hit = sh_valid[addr[7:4]] && (sh_tag[addr[7:4]] == addr[9:8]);
    exp = ref_mem[addr[9:2]];
    rd0 = rd_acks;
    wr0 = wr_acks;
    @(negedge clk);
    dmem_ren   = 1'b1;
    dmem_raddr = addr;
    issued++;
    #1;
    check_true(!dmem_stall, "cache load stalled in its request cycle");
    @(negedge clk);
    dmem_ren   = 1'b0;
    // CPU moves on, the fill has to use the bridge's own copy
    dmem_raddr = ~addr;
    #1;
    if (hit) begin
      check_true(!dmem_stall, "predicted hit raised the stall");
    end else begin
      check_true(dmem_stall, "predicted miss did not raise the stall");
    end
    while (dmem_stall) begin
      @(negedge clk);
    end
    check_value(hit ? "load_hit" : "load_miss", exp, dmem_rdata);
    check_value("load_fill_reads", hit ? 32'd0 : 32'(WORDS), 32'(rd_acks - rd0));
    check_value("load_bus_writes", 32'd0, 32'(wr_acks - wr0));
    sh_valid[addr[7:4]] = 1'b1;
    sh_tag[addr[7:4]]   = addr[9:8];
  endtask

  task automatic cache_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    int rd0;
    int wr0;
    rd0 = rd_acks;
    wr0 = wr_acks;
    @(negedge clk);
    dmem_we      = 1'b1;
    dmem_wr.addr = addr;
    dmem_wr.data = data;
    dmem_wr.strb = strb;
    issued++;
    #1;
    check_true(!dmem_stall, "cache store stalled in its accept cycle");
    @(negedge clk);
    dmem_we      = 1'b0;
    // Store port changes, the write-through must come from the bridge copy
    dmem_wr.addr = ~addr;
    dmem_wr.data = ~data;
    dmem_wr.strb = ~strb;
    #1;
    check_true(dmem_stall, "store did not stall for its write-through");
    while (dmem_stall) begin
      @(negedge clk);
    end
    check_value("store_bus_writes", 32'd1, 32'(wr_acks - wr0));
    check_value("store_bus_reads", 32'd0, 32'(rd_acks - rd0));
    check_value("store_adr", {addr[31:2], 2'b00}, last_wr_adr);
    check_value("store_dat", data, last_wr_dat);
    check_value("store_sel", 32'(strb), 32'(last_wr_sel));
    // Write-through without allocate, shadow stays as it is
    ref_mem[addr[9:2]] = merge_bytes(ref_mem[addr[9:2]], data, strb);
  endtask

  task automatic io_load(input logic [31:0] addr);
    logic [31:0] exp;
    int          rd0;
    int          wr0;
    exp = io_ref[addr[4:2]];
    rd0 = rd_acks;
    wr0 = wr_acks;
    @(negedge clk);
    dmem_ren   = 1'b1;
    dmem_raddr = addr;
    issued++;
    #1;
    check_true(!dmem_stall, "I/O load stalled");
    @(negedge clk);
    dmem_ren = 1'b0;
    #1;
    check_true(!dmem_stall, "I/O load stalled after its request");
    check_value("io_load", exp, dmem_rdata);
    check_value("io_load_bus", 32'd0, 32'((rd_acks - rd0) + (wr_acks - wr0)));
  endtask

  task automatic io_store(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    int rd0;
    int wr0;
    rd0 = rd_acks;
    wr0 = wr_acks;
    @(negedge clk);
    dmem_we      = 1'b1;
    dmem_wr.addr = addr;
    dmem_wr.data = data;
    dmem_wr.strb = strb;
    issued++;
    #1;
    check_true(!dmem_stall, "I/O store stalled");
    @(negedge clk);
    dmem_we = 1'b0;
    #1;
    check_true(!dmem_stall, "I/O store stalled after its request");
    check_value("io_store_bus", 32'd0, 32'((rd_acks - rd0) + (wr_acks - wr0)));
    io_ref[addr[4:2]] = merge_bytes(io_ref[addr[4:2]], data, strb);
  endtask

  initial begin
    logic [31:0] op;
    logic [31:0] w;
    logic [31:0] tag;
    logic [31:0] idx;
    logic [31:0] word;
    logic [31:0] data;
    logic [31:0] strb;
    logic [31:0] rsel;
    logic [31:0] junk;
    logic [31:0] caddr;
    logic [31:0] iaddr;
    clk         = 1'b0;
    rst_n       = 1'b0;
    dmem_ren    = 1'b0;
    dmem_raddr  = '0;
    dmem_we     = 1'b0;
    dmem_wr     = '0;
    wait_cycles = 2'd0;
    lfsr_q      = 16'd3563;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    issued      = 0;
    taken       = 0;
    rd_acks     = 0;
    wr_acks     = 0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = mem_init_word(32'(i) << 2);
    end
    for (int i = 0; i < 16; i++) begin
      sh_valid[i] = 1'b0;
      sh_tag[i]   = 2'd0;
    end
    for (int i = 0; i < 8; i++) begin
      io_ref[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_true(!dmem_stall, "stall high after reset");
    check_true(!wb_o.cyc, "Wishbone cyc high after reset");
    // All I/O registers start at zero
    for (int r = 0; r < 8; r++) begin
      io_load({1'b1, 26'd0, 3'(r), 2'b00});
    end
    for (int i = 0; i < NUM_OPS; i++) begin
      draw(3, op);
      draw(2, w);
      draw(2, tag);
      draw(4, idx);
      draw(2, word);
      draw(32, data);
      draw(4, strb);
      draw(3, rsel);
      draw(8, junk);
      wait_cycles = w[1:0];
      // Four tags over sixteen lines keep hits and conflicts frequent
      caddr = {22'd0, tag[1:0], idx[3:0], word[1:0], 2'b00};
      iaddr = {1'b1, 18'd0, junk[7:0], rsel[2:0], 2'b00};
      case (op[2:0])
        3'd3, 3'd4: cache_store(caddr, data, strb[3:0]);
        3'd5: io_load(iaddr);
        3'd6: io_store(iaddr, data, strb[3:0]);
        default: cache_load(caddr);
      endcase
    end
    check_value("op_count", 32'(issued), 32'(taken));
    $display("Checks %0d, errors %0d, operations %0d", checks, errors, taken);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: tests/wb_mem_model.sv
module wb_mem_model
  import dmem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // Wait states inserted before each ack
  input  logic [1:0] wait_cycles,
  input  wb_m2s_t    m2s,
  output wb_s2m_t    s2m
);

  logic [31:0] mem [1024];
  logic [1:0]  wait_cnt;
  logic [9:0]  widx;
  logic        take;

  // Fill pattern built from the full byte address
  function automatic logic [31:0] mem_init_word(input logic [31:0] a);
    return (a * 32'h9E3779B1) ^ {a[15:0], ~a[15:0]};
  endfunction

  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = mem_init_word(32'(i) << 2);
    end
  end

  assign widx = m2s.adr[11:2];
  // Cycle is answered once the wait count runs out
  assign take = m2s.cyc && m2s.stb && !s2m.ack && (wait_cnt == wait_cycles);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2m      <= '0;
      wait_cnt <= '0;
    end else begin
      // Ack is a one-cycle pulse per transfer
      s2m.ack <= 1'b0;
      if (take) begin
        s2m.ack  <= 1'b1;
        wait_cnt <= '0;
        if (!m2s.we) begin
          s2m.dat <= mem[widx];
        end
      end else if (m2s.cyc && m2s.stb && !s2m.ack) begin
        wait_cnt <= wait_cnt + 2'd1;
      end
    end
  end

  // Write data lands under the byte selects
  always @(posedge clk) begin
    if (take && m2s.we) begin
      for (int b = 0; b < 4; b++) begin
        if (m2s.sel[b]) begin
          mem[widx][8*b +: 8] <= m2s.dat[8*b +: 8];
        end
      end
    end
  end

endmodule
